//--- hdl/rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;	// data or address
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b	// lui
	} alu_op_t;

	typedef enum logic [2:0] {fmt_i, fmt_s, fmt_b, fmt_u, fmt_j} imm_fmt_t;

	typedef enum logic [2:0] {st_fetch, st_decode, st_exec, st_mem, st_wb} cpu_state_t;

	// major opcodes of the supported subset
	localparam opcode_t op_reg    = 7'b0110011;
	localparam opcode_t op_imm    = 7'b0010011;
	localparam opcode_t op_lui    = 7'b0110111;
	localparam opcode_t op_load   = 7'b0000011;
	localparam opcode_t op_store  = 7'b0100011;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_jal    = 7'b1101111;

	localparam logic [1:0] br_none = 2'd0;	// pc unit next-address kinds
	localparam logic [1:0] br_beq  = 2'd1;
	localparam logic [1:0] br_bne  = 2'd2;
	localparam logic [1:0] br_jal  = 2'd3;

	localparam logic [1:0] wb_alu  = 2'd0;	// writeback sources
	localparam logic [1:0] wb_load = 2'd1;
	localparam logic [1:0] wb_pc4  = 2'd2;

	localparam word_t reset_pc = 32'h0000_0000;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             rd_en,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data,
	input  logic             we,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    rd_data
);

	rv_pkg::word_t regs [1:31];	// x0 has no storage

	always_ff @(posedge sys_clk) begin
		if (we)
			regs[rd] <= rd_data;
	end

	// operands latched once per instruction, in decode
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rs1_data <= (rs1 == '0) ? '0 : regs[rs1];
			rs2_data <= (rs2 == '0) ? '0 : regs[rs2];
		end
	end

	// the sequencer filters rd == 0 before it raises we
	a_no_x0_write: assert property (@(posedge sys_clk) disable iff (sys_rst)
		we |-> rd != '0);

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic            sys_clk,
	input  logic            sys_rst,
	input  logic            en,
	input  rv_pkg::alu_op_t op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output logic            eq,
	output rv_pkg::word_t   result
);

	rv_pkg::word_t res_next;

	always_comb begin
		case (op)
			rv_pkg::alu_add:    res_next = a + b;
			rv_pkg::alu_sub:    res_next = a - b;
			rv_pkg::alu_and:    res_next = a & b;
			rv_pkg::alu_or:     res_next = a | b;
			rv_pkg::alu_xor:    res_next = a ^ b;
			rv_pkg::alu_pass_b: res_next = b;
			default:            res_next = a + b;
		endcase
	end

	assign eq = (a == b);	// branch compare, rs1 against rs2

	// result doubles as the data bus address
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			result <= '0;
		else if (en)
			result <= res_next;
	end

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_pkg::word_t    instr,
	input  rv_pkg::imm_fmt_t imm_fmt,
	output rv_pkg::word_t    imm
);

	always_comb begin
		case (imm_fmt)
			rv_pkg::fmt_i: imm = {{20{instr[31]}}, instr[31:20]};
			rv_pkg::fmt_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// b and j offsets are in halfwords, bit 0 implied
			rv_pkg::fmt_b: imm = {{19{instr[31]}}, instr[31], instr[7],
				instr[30:25], instr[11:8], 1'b0};
			rv_pkg::fmt_u: imm = {instr[31:12], 12'h000};
			rv_pkg::fmt_j: imm = {{11{instr[31]}}, instr[31], instr[19:12],
				instr[20], instr[30:21], 1'b0};
			default:       imm = '0;
		endcase
	end

endmodule

//--- hdl/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input  logic          sys_clk,
	input  logic          sys_rst,
	input  logic          pc_en,
	input  logic [1:0]    br_kind,
	input  logic          eq,
	input  rv_pkg::word_t imm,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t pc_plus4
);

	logic taken;

	assign pc_plus4 = pc + 32'd4;	// also the jal link value

	always_comb begin
		case (br_kind)
			rv_pkg::br_beq: taken = eq;
			rv_pkg::br_bne: taken = !eq;
			rv_pkg::br_jal: taken = 1'b1;
			default:        taken = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			pc <= rv_pkg::reset_pc;
		else if (pc_en)
			pc <= taken ? pc + imm : pc_plus4;
	end

	a_pc_aligned: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pc[1:0] == 2'b00);

endmodule

//--- hdl/load_store.sv
`timescale 1ns/1ps

module load_store (
	input  logic          sys_clk,
	input  logic          sys_rst,
	input  rv_pkg::word_t addr,
	input  rv_pkg::word_t store_data,
	input  logic          st_byte,
	input  logic          ld_byte,
	input  logic          data_ack,
	input  logic          data_we,
	input  rv_pkg::word_t data_data_in,
	output logic [3:0]    data_be,
	output rv_pkg::word_t data_data_out,
	output rv_pkg::word_t load_data
);

	logic [7:0] ld_lane;

	// one lane for byte access, all four for words
	assign data_be = (st_byte || ld_byte) ? (4'b0001 << addr[1:0]) : 4'b1111;
	assign data_data_out = st_byte ? {4{store_data[7:0]}} : store_data;

	assign ld_lane = data_data_in[{addr[1:0], 3'b000} +: 8];

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			load_data <= '0;
		else if (data_ack && !data_we)	// read acknowledge only
			load_data <= ld_byte ? {24'h000000, ld_lane} : data_data_in;
	end

endmodule

//--- hdl/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl (
	input  logic             sys_clk,
	input  logic             sys_rst,
	output logic             inst_cyc,
	output logic             inst_stb,
	input  logic             inst_stall,
	input  logic             inst_ack,
	input  rv_pkg::word_t    inst_data,
	output logic             data_stb,
	output logic             data_we,
	input  logic             data_ack,
	input  logic             eq,
	output rv_pkg::reg_idx_t rs1,
	output rv_pkg::reg_idx_t rs2,
	output rv_pkg::reg_idx_t rd,
	output logic             rf_rd_en,
	output logic             rf_we,
	output rv_pkg::imm_fmt_t imm_fmt,
	output rv_pkg::word_t    instr,
	output rv_pkg::alu_op_t  alu_op,
	output logic             alu_b_imm,
	output logic             alu_a_pc,
	output logic             alu_en,
	output logic [1:0]       wb_sel,
	output logic             pc_en,
	output logic [1:0]       br_kind,
	output logic             ld_byte,
	output logic             st_byte
);

	rv_pkg::cpu_state_t state;
	rv_pkg::opcode_t    opcode;
	logic [2:0]         funct3;
	logic [6:0]         funct7;
	logic [1:0]         br_dec;	// branch kind before the eq check
	logic               wr_rd;
	logic               is_mem;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd  = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	always_comb begin
		alu_op = rv_pkg::alu_add;
		alu_b_imm = 1'b0;
		alu_a_pc = 1'b0;
		imm_fmt = rv_pkg::fmt_i;
		wb_sel = rv_pkg::wb_alu;
		br_dec = rv_pkg::br_none;
		wr_rd = 1'b0;
		is_mem = 1'b0;
		ld_byte = 1'b0;
		st_byte = 1'b0;
		case (opcode)
			rv_pkg::op_reg: begin
				wr_rd = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
				case (funct3)
					3'b000: alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
					3'b100: alu_op = rv_pkg::alu_xor;
					3'b110: alu_op = rv_pkg::alu_or;
					3'b111: alu_op = rv_pkg::alu_and;
					default: wr_rd = 1'b0;	// shifts and slt not supported
				endcase
			end
			rv_pkg::op_imm: begin
				alu_b_imm = 1'b1;
				wr_rd = (funct3 == 3'b000);	// addi only
			end
			rv_pkg::op_lui: begin
				alu_op = rv_pkg::alu_pass_b;
				alu_b_imm = 1'b1;
				imm_fmt = rv_pkg::fmt_u;
				wr_rd = 1'b1;
			end
			rv_pkg::op_load: begin
				alu_b_imm = 1'b1;
				wb_sel = rv_pkg::wb_load;
				is_mem = (funct3 == 3'b010) || (funct3 == 3'b100);	// lw, lbu
				wr_rd = is_mem;
				ld_byte = (funct3 == 3'b100);
			end
			rv_pkg::op_store: begin
				alu_b_imm = 1'b1;
				imm_fmt = rv_pkg::fmt_s;
				is_mem = (funct3 == 3'b010) || (funct3 == 3'b000);	// sw, sb
				st_byte = (funct3 == 3'b000);
			end
			rv_pkg::op_branch: begin
				imm_fmt = rv_pkg::fmt_b;
				if (funct3 == 3'b000)
					br_dec = rv_pkg::br_beq;
				else if (funct3 == 3'b001)
					br_dec = rv_pkg::br_bne;
			end
			rv_pkg::op_jal: begin
				alu_a_pc = 1'b1;	// alu forms the target, pc unit takes its own sum
				alu_b_imm = 1'b1;
				imm_fmt = rv_pkg::fmt_j;
				wb_sel = rv_pkg::wb_pc4;
				br_dec = rv_pkg::br_jal;
				wr_rd = 1'b1;
			end
			default: ;	// anything else runs as a nop
		endcase
	end

	assign rf_rd_en = (state == rv_pkg::st_decode);
	assign alu_en   = (state == rv_pkg::st_exec);
	assign rf_we    = (state == rv_pkg::st_wb) && wr_rd && (rd != '0);
	assign pc_en    = (state == rv_pkg::st_wb);

	always_ff @(posedge sys_clk) begin
		if (inst_cyc && inst_ack)
			instr <= inst_data;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= rv_pkg::st_fetch;
			inst_cyc <= 1'b0;
			inst_stb <= 1'b0;
			data_stb <= 1'b0;
			data_we <= 1'b0;
			br_kind <= rv_pkg::br_none;
		end else begin
			case (state)
				rv_pkg::st_fetch: begin
					if (!inst_cyc) begin	// only right after reset
						inst_cyc <= 1'b1;
						inst_stb <= 1'b1;
					end else if (inst_ack) begin
						inst_cyc <= 1'b0;
						inst_stb <= 1'b0;
						state <= rv_pkg::st_decode;
					end else if (!inst_stall) begin
						inst_stb <= 1'b0;	// request taken
					end
				end
				rv_pkg::st_decode: state <= rv_pkg::st_exec;
				rv_pkg::st_exec: begin
					// branch resolved here, pc moves in writeback
					if ((br_dec == rv_pkg::br_beq && !eq) || (br_dec == rv_pkg::br_bne && eq))
						br_kind <= rv_pkg::br_none;
					else
						br_kind <= br_dec;
					if (is_mem) begin
						data_stb <= 1'b1;
						data_we <= (opcode == rv_pkg::op_store);
						state <= rv_pkg::st_mem;
					end else begin
						state <= rv_pkg::st_wb;
					end
				end
				rv_pkg::st_mem: begin
					if (data_ack) begin
						data_stb <= 1'b0;
						data_we <= 1'b0;
						state <= rv_pkg::st_wb;
					end
				end
				rv_pkg::st_wb: begin
					inst_cyc <= 1'b1;	// next fetch request
					inst_stb <= 1'b1;
					state <= rv_pkg::st_fetch;
				end
				default: state <= rv_pkg::st_fetch;
			endcase
		end
	end

	a_stb_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
		inst_stb |-> inst_cyc);

	a_data_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		data_stb && !data_ack |=> data_stb);

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	output logic          inst_cyc,
	output logic          inst_stb,
	output rv_pkg::word_t inst_addr,
	input  logic          inst_ack,
	input  rv_pkg::word_t inst_data,
	input  logic          inst_stall,
	output logic          data_stb,
	output logic          data_we,
	output logic [3:0]    data_be,
	input  logic          data_ack,
	output rv_pkg::word_t data_addr,
	output rv_pkg::word_t data_data_out,
	input  rv_pkg::word_t data_data_in,
	input  logic          sys_clk,
	input  logic          sys_rst
);

	rv_pkg::reg_idx_t rs1, rs2, rd;
	rv_pkg::imm_fmt_t imm_fmt;
	rv_pkg::alu_op_t  alu_op;
	rv_pkg::word_t    instr, imm, rs1_data, rs2_data, pc_plus4, load_data;
	logic             rf_rd_en, rf_we, alu_b_imm, alu_a_pc, alu_en, pc_en;
	logic             eq, ld_byte, st_byte;
	logic [1:0]       wb_sel, br_kind;

	cpu_ctrl u_ctrl (
		.sys_clk, .sys_rst, .inst_cyc, .inst_stb, .inst_stall, .inst_ack, .inst_data,
		.data_stb, .data_we, .data_ack, .eq, .rs1, .rs2, .rd, .rf_rd_en, .rf_we,
		.imm_fmt, .instr, .alu_op, .alu_b_imm, .alu_a_pc, .alu_en, .wb_sel, .pc_en,
		.br_kind, .ld_byte, .st_byte
	);

	// writeback source picked at the write port
	reg_file u_rf (
		.sys_clk, .sys_rst, .rd_en(rf_rd_en), .rs1, .rs2, .rs1_data, .rs2_data,
		.we(rf_we), .rd,
		.rd_data(wb_sel == rv_pkg::wb_load ? load_data :
			wb_sel == rv_pkg::wb_pc4 ? pc_plus4 : data_addr)
	);

	imm_gen u_imm (.instr, .imm_fmt, .imm);

	alu u_alu (
		.sys_clk, .sys_rst, .en(alu_en), .op(alu_op),
		.a(alu_a_pc ? inst_addr : rs1_data),
		.b(alu_b_imm ? imm : rs2_data),
		.eq, .result(data_addr)	// alu result register drives the data address
	);

	pc_unit u_pc (
		.sys_clk, .sys_rst, .pc_en, .br_kind, .eq, .imm,
		.pc(inst_addr), .pc_plus4
	);

	load_store u_ls (
		.sys_clk, .sys_rst, .addr(data_addr), .store_data(rs2_data), .st_byte, .ld_byte,
		.data_ack, .data_we, .data_data_in, .data_be, .data_data_out, .load_data
	);

endmodule

//--- tb/bus_mem.sv
`timescale 1ns/1ps

module bus_mem (
	input  logic          sys_clk,
	input  logic          inst_cyc,
	input  logic          inst_stb,
	input  rv_pkg::word_t inst_addr,
	output logic          inst_stall,
	output logic          inst_ack,
	output rv_pkg::word_t inst_data,
	input  logic          data_stb,
	input  logic          data_we,
	input  logic [3:0]    data_be,
	input  rv_pkg::word_t data_addr,
	input  rv_pkg::word_t data_data_out,
	output logic          data_ack,
	output rv_pkg::word_t data_data_in
);

	rv_pkg::word_t imem [0:63];	// written by the testbench
	rv_pkg::word_t dmem [0:255];
	rv_pkg::word_t i_addr;
	integer        seed = 32'h6a338e08;
	int            i_phase = 0;	// 0 idle, 1 stalling, 2 waiting to ack
	int            i_wait = 0;
	int            d_busy = 0;
	int            d_wait = 0;

	initial begin
		inst_stall = 1'b0;
		inst_ack = 1'b0;
		inst_data = '0;
		data_ack = 1'b0;
		data_data_in = '0;
		for (int k = 0; k < 256; k++)
			dmem[k] = 32'hd500_0000 + k * 32'h0001_0101;
	end

	// responses change 1 ns after the edge, seen by the cpu at the next one
	always @(posedge sys_clk) begin
		#1;
		inst_ack = 1'b0;
		inst_stall = 1'b0;
		data_ack = 1'b0;
		if (i_phase == 0 && inst_cyc && inst_stb) begin
			i_wait = $random(seed) & 3;
			i_phase = 1;
		end
		if (i_phase == 1) begin
			if (i_wait > 0) begin
				inst_stall = 1'b1;
				i_wait = i_wait - 1;
			end else begin
				i_addr = inst_addr;	// request taken this cycle
				i_wait = $random(seed) & 3;
				i_phase = 2;
			end
		end else if (i_phase == 2) begin
			if (i_wait > 0) begin
				i_wait = i_wait - 1;
			end else begin
				inst_ack = 1'b1;
				inst_data = imem[i_addr[7:2]];
				i_phase = 0;
			end
		end
		if (d_busy == 0 && data_stb) begin
			d_wait = $random(seed) & 3;
			d_busy = 1;
		end
		if (d_busy == 1) begin
			if (d_wait > 0) begin
				d_wait = d_wait - 1;
			end else begin
				data_ack = 1'b1;
				d_busy = 0;
				if (data_we) begin
					for (int b = 0; b < 4; b++)
						if (data_be[b])
							dmem[data_addr[9:2]][8*b +: 8] = data_data_out[8*b +: 8];
				end else begin
					data_data_in = dmem[data_addr[9:2]];
				end
			end
		end
	end

endmodule

//--- tb/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

	localparam int max_stores = 32;
	localparam int cycles_per_instr = 16;	// 8 fetch, 4 data, decode, exec, wb, slack
	localparam logic [6:0] opc_imm  = 7'b0010011;
	localparam logic [6:0] opc_load = 7'b0000011;

	logic             sys_clk = 1'b0;
	logic             sys_rst = 1'b1;
	logic             inst_cyc, inst_stb, inst_ack, inst_stall;
	logic             data_stb, data_we, data_ack;
	logic [3:0]       data_be;
	rv_pkg::word_t    inst_addr, inst_data, data_addr, data_data_out, data_data_in;

	int               cycle = 0;
	int               max_cycles = 0;
	int               errors = 0;
	int               tests = 0;
	int               failed = 0;
	int               prog_len = 0;
	int               n_exp = 0;
	int               n_seen = 0;
	logic             fetch_seen = 1'b0;
	string            exp_name [0:max_stores-1];
	rv_pkg::word_t    exp_addr [0:max_stores-1];
	logic [3:0]       exp_be [0:max_stores-1];
	rv_pkg::word_t    exp_data [0:max_stores-1];

	// program constants
	logic [11:0]      k_a = 12'h2a5;
	logic [11:0]      k_b = 12'hf37;	// negative
	logic [19:0]      k_u = 20'h8badf;
	logic [11:0]      k_c = 12'h5c3;
	rv_pkg::word_t    base = 32'h0000_0100;
	rv_pkg::word_t    trap_addr = 32'h0000_0180;
	rv_pkg::word_t    va, vb, vu, vc, v_add, v_sub, v_and, v_or, v_xor;

	cpu_top uut (.*);
	bus_mem mem (.*);

	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle <= cycle + 1;
		if (inst_stb)
			fetch_seen <= 1'b1;
	end

	function automatic rv_pkg::word_t sign_ext(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic rv_pkg::word_t rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic rv_pkg::word_t stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv_pkg::word_t btype(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::word_t utype(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic rv_pkg::word_t jtype(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input rv_pkg::word_t w);
		mem.imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_store(input string name, input rv_pkg::word_t addr,
		input logic [3:0] be, input rv_pkg::word_t data);
		exp_name[n_exp] = name;
		exp_addr[n_exp] = addr;
		exp_be[n_exp] = be;
		exp_data[n_exp] = data;
		n_exp++;
	endtask

	// sw rs2, off(x10)
	task automatic store_word(input string name, input logic [4:0] rs2,
		input logic [11:0] off, input rv_pkg::word_t value);
		emit(stype(off, rs2, 5'd10, 3'b010));
		expect_store(name, base + sign_ext(off), 4'hf, value);
	endtask

	// sb rs2, off(x10)
	task automatic store_byte(input string name, input logic [4:0] rs2,
		input logic [11:0] off, input logic [3:0] be, input logic [7:0] value);
		emit(stype(off, rs2, 5'd10, 3'b000));
		expect_store(name, base + sign_ext(off), be, {4{value}});
	endtask

	task automatic compare_store();
		bit ok;
		ok = 1'b1;
		if (n_seen >= n_exp) begin
			$display("unexpected store to %h after the last expected store", data_addr);
			errors++;
		end else begin
			assert (data_addr == exp_addr[n_seen]) else begin
				$display("Error %s address expected %h actual %h", exp_name[n_seen],
					exp_addr[n_seen], data_addr);
				ok = 1'b0;
			end
			assert (data_be == exp_be[n_seen]) else begin
				$display("Error %s byte enables expected %b actual %b", exp_name[n_seen],
					exp_be[n_seen], data_be);
				ok = 1'b0;
			end
			assert (data_data_out == exp_data[n_seen]) else begin
				$display("Error %s data expected %h actual %h", exp_name[n_seen],
					exp_data[n_seen], data_data_out);
				ok = 1'b0;
			end
			tests++;
			if (ok) begin
				$display("test %s ok", exp_name[n_seen]);
			end else begin
				$display("test %s failed", exp_name[n_seen]);
				failed++;
			end
			n_seen++;
		end
	endtask

	always @(negedge sys_clk) begin	// bus values are settled mid cycle
		if (!sys_rst && data_stb && data_ack && data_we)
			compare_store();
	end

	a_reset_quiet: assert property (@(posedge sys_clk) cycle >= 1 && $past(sys_rst)
		|-> !inst_cyc && !inst_stb && !data_stb) else begin
		$display("a bus strobe was active during reset or right after it");
		errors++;
	end

	a_first_fetch: assert property (@(posedge sys_clk) inst_stb && !fetch_seen
		|-> inst_addr == 32'h0) else begin
		$display("Error first_fetch expected %h actual %h", 32'h0, $sampled(inst_addr));
		errors++;
	end

	a_inst_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		inst_stb && inst_stall |=> inst_stb && $stable(inst_addr)) else begin
		$display("instruction request dropped or moved while stalled");
		errors++;
	end

	a_data_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		data_stb && !data_ack |=> data_stb && $stable(data_addr) && $stable(data_be)
			&& $stable(data_we) && $stable(data_data_out)) else begin
		$display("data request dropped or changed before its acknowledge");
		errors++;
	end

	// taken branches and jal must skip these stores
	a_no_trap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		data_stb |-> data_addr != trap_addr) else begin
		$display("a skipped store reached the trap address %h", trap_addr);
		errors++;
	end

	initial begin
		va = sign_ext(k_a);
		vb = sign_ext(k_b);
		vu = {k_u, 12'h000};
		vc = vu + sign_ext(k_c);
		v_add = va + vb;
		v_sub = va - vb;
		v_and = vb & vc;
		v_or = va | vc;
		v_xor = vb ^ vc;
		for (int k = 0; k < 64; k++)
			mem.imem[k] = itype(12'(k), 5'd0, 3'b000, 5'd0, opc_imm);	// addi x0 nops

		emit(itype(base[11:0], 5'd0, 3'b000, 5'd10, opc_imm));
		emit(itype(k_a, 5'd0, 3'b000, 5'd1, opc_imm));
		emit(itype(k_b, 5'd0, 3'b000, 5'd2, opc_imm));
		emit(utype(k_u, 5'd3));
		emit(itype(k_c, 5'd3, 3'b000, 5'd4, opc_imm));
		store_word("addi", 5'd1, 12'd0, va);
		store_word("lui", 5'd3, 12'd4, vu);
		store_word("addi_rs", 5'd4, 12'd8, vc);
		emit(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
		store_word("arith_add", 5'd5, 12'd12, v_add);
		emit(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
		store_word("arith_sub", 5'd5, 12'd16, v_sub);
		emit(rtype(7'h00, 5'd4, 5'd2, 3'b111, 5'd5));
		store_word("logic_and", 5'd5, 12'd20, v_and);
		emit(rtype(7'h00, 5'd4, 5'd1, 3'b110, 5'd5));
		store_word("logic_or", 5'd5, 12'd24, v_or);
		emit(rtype(7'h00, 5'd4, 5'd2, 3'b100, 5'd5));
		store_word("logic_xor", 5'd5, 12'd28, v_xor);
		emit(itype(12'h7ff, 5'd0, 3'b000, 5'd0, opc_imm));	// x0 stays zero
		store_word("x0_zero", 5'd0, 12'd32, 32'h0);

		store_byte("sb_lane0", 5'd4, 12'd64, 4'b0001, vc[7:0]);
		store_byte("sb_lane1", 5'd1, 12'd65, 4'b0010, va[7:0]);
		store_byte("sb_lane2", 5'd2, 12'd66, 4'b0100, vb[7:0]);
		store_byte("sb_lane3", 5'd5, 12'd67, 4'b1000, v_xor[7:0]);
		emit(itype(12'd66, 5'd10, 3'b100, 5'd6, opc_load));
		store_word("lbu_lane2", 5'd6, 12'd68, {24'h0, vb[7:0]});
		emit(itype(12'd67, 5'd10, 3'b100, 5'd7, opc_load));	// top bit set
		store_word("lbu_lane3", 5'd7, 12'd72, {24'h0, v_xor[7:0]});
		emit(itype(12'd12, 5'd10, 3'b010, 5'd8, opc_load));
		store_word("lw_back", 5'd8, 12'd76, v_add);

		emit(btype(13'd8, 5'd1, 5'd1, 3'b000));	// beq taken
		emit(stype(12'h080, 5'd1, 5'd10, 3'b010));
		emit(btype(13'd8, 5'd2, 5'd1, 3'b001));	// bne taken
		emit(stype(12'h080, 5'd1, 5'd10, 3'b010));
		emit(btype(13'd8, 5'd2, 5'd1, 3'b000));
		store_word("beq_fall", 5'd2, 12'd80, vb);
		emit(btype(13'd8, 5'd1, 5'd1, 3'b001));
		store_word("bne_fall", 5'd1, 12'd84, va);
		emit(jtype(21'd8, 5'd9));
		emit(stype(12'h080, 5'd1, 5'd10, 3'b010));
		store_word("jal_link", 5'd9, 12'd88, 32'((prog_len - 2) * 4 + 4));
		emit(jtype(21'd0, 5'd0));	// park here

		max_cycles = 10 + prog_len * cycles_per_instr;
		repeat (10) @(posedge sys_clk);
		#1 sys_rst = 1'b0;

		while (n_seen < n_exp && cycle < max_cycles)
			@(posedge sys_clk);
		if (n_seen < n_exp) begin
			$display("timeout after %0d cycles with %0d of %0d stores seen", cycle, n_seen,
				n_exp);
			errors++;
		end
		repeat (20) @(posedge sys_clk);	// room for a stray store

		$display("%0d tests, %0d failed, %0d other errors", tests, failed, errors);
		if (failed == 0 && errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- src.f
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/pc_unit.sv
hdl/load_store.sv
hdl/cpu_ctrl.sv
hdl/cpu_top.sv
tb/bus_mem.sv
tb/tb_cpu_top.sv

//--- Bender.yml
package:
  name: rv32i_seq_core

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/imm_gen.sv
      - hdl/pc_unit.sv
      - hdl/load_store.sv
      - hdl/cpu_ctrl.sv
      - hdl/cpu_top.sv
  - target: test
    files:
      - tb/bus_mem.sv
      - tb/tb_cpu_top.sv
